// File: common/dma_defs.svh
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// bytes moved per copy, one full OAM table
`define DMA_LEN 160

// entries in the read-to-write buffer
`define DMA_BUF_DEPTH 4

// source pages served by video RAM, inclusive
`define DMA_VRAM_PAGE_LO 8'h80
`define DMA_VRAM_PAGE_HI 8'h9F

`endif

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// 16-bit address space of the console bus
	typedef logic [15:0] addr_t;

	// one data byte
	typedef logic [7:0] byte_t;

	// where a copy reads its source bytes from
	typedef enum logic {
		region_ext,  // cartridge / work RAM side
		region_vram  // video RAM side
	} region_e;

endpackage

`default_nettype wire

// File: common/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// byte position within one copy, 0 to 159
	typedef logic [7:0] index_t;

	// engine control states
	typedef enum logic [1:0] {
		st_idle,  // no copy
		st_start, // page latched, reads begin next cycle
		st_copy   // reads running
	} state_e;

endpackage

`default_nettype wire

// File: common/xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface xfer_if;

	logic             stb;   // item valid this cycle
	bus_pkg::byte_t   data;  // payload byte
	dma_pkg::index_t  index; // OAM position of the byte
	logic             last;  // final byte of the copy
	logic             hold;  // receiver pause level

	modport src (
		output stb,
		output data,
		output index,
		output last,
		input  hold
	);

	modport dst (
		input  stb,
		input  data,
		input  index,
		input  last,
		output hold
	);

endinterface

`default_nettype wire

// File: dma/dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_engine (
	input  wire logic            clk1,
	input  wire logic            rst_n,
	input  wire logic            reg_sel,
	input  wire logic            reg_wr,
	input  wire logic            reg_rd,
	input  wire bus_pkg::byte_t  cpu_wdata,
	output      bus_pkg::byte_t  cpu_rdata,
	output      bus_pkg::addr_t  ext_addr,
	output      logic            ext_rd,
	input  wire bus_pkg::byte_t  ext_rdata,
	output      bus_pkg::addr_t  vram_addr,
	output      logic            vram_rd,
	input  wire bus_pkg::byte_t  vram_rdata,
	input  wire logic            done,
	output      logic            dma_run,
	output      logic            flush,
	xfer_if.src                  out
);

	localparam dma_pkg::index_t last_idx = dma_pkg::index_t'(`DMA_LEN - 1);
	localparam dma_pkg::index_t len_idx  = dma_pkg::index_t'(`DMA_LEN);

	bus_pkg::byte_t   page_q;
	dma_pkg::state_e  state_q;
	dma_pkg::index_t  rd_idx_q;   // next byte to read
	dma_pkg::index_t  pend_idx_q; // index of the read in flight
	logic             pend_q;
	logic             run_q;
	logic             reg_write;
	logic             rd_go;
	bus_pkg::region_e region;

	assign reg_write = reg_sel && reg_wr;

	// video pages come from VRAM, all else from the external bus
	assign region = (page_q >= `DMA_VRAM_PAGE_LO && page_q <= `DMA_VRAM_PAGE_HI) ?
		bus_pkg::region_vram : bus_pkg::region_ext;

	assign rd_go = (state_q == dma_pkg::st_copy) && !out.hold &&
		(rd_idx_q < len_idx) && !reg_write;

	assign ext_rd    = rd_go && (region == bus_pkg::region_ext);
	assign vram_rd   = rd_go && (region == bus_pkg::region_vram);
	assign ext_addr  = {page_q, rd_idx_q};  // page * 256 + index
	assign vram_addr = {page_q, rd_idx_q};

	assign cpu_rdata = (reg_sel && reg_rd) ? page_q : '0;
	assign flush     = reg_write && (state_q != dma_pkg::st_idle); // restart only
	assign dma_run   = run_q;

	// read data lands one cycle after the strobe
	assign out.stb   = pend_q;
	assign out.index = pend_idx_q;
	assign out.last  = (pend_idx_q == last_idx);
	assign out.data  = (region == bus_pkg::region_vram) ? vram_rdata : ext_rdata;

	always_ff @(posedge clk1) begin
		if (!rst_n) begin
			page_q   <= '0;
			state_q  <= dma_pkg::st_idle;
			rd_idx_q <= '0;
			pend_q   <= 1'b0;
			run_q    <= 1'b0;
		end else begin
			pend_q <= rd_go; // a restart drops the read in flight
			if (reg_write) begin
				page_q   <= cpu_wdata;
				state_q  <= dma_pkg::st_start;
				rd_idx_q <= '0;
			end else begin
				case (state_q)
					dma_pkg::st_start: begin
						state_q <= dma_pkg::st_copy;
						run_q   <= 1'b1;
					end
					dma_pkg::st_copy: begin
						if (rd_go)
							rd_idx_q <= rd_idx_q + 8'd1;
						if (done) begin // final OAM write went out
							state_q <= dma_pkg::st_idle;
							run_q   <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk1) begin
		pend_idx_q <= rd_idx_q;
	end

	a_one_source: assert property (@(posedge clk1) disable iff (!rst_n)
		!(ext_rd && vram_rd));

endmodule

`default_nettype wire

// File: dma/dma_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_buffer (
	input wire logic clk1,
	input wire logic rst_n,
	input wire logic flush,
	xfer_if.dst      in,
	xfer_if.src      out
);

	localparam int depth = `DMA_BUF_DEPTH;
	localparam int ptr_w = $clog2(depth);

	bus_pkg::byte_t   data_mem [depth];
	dma_pkg::index_t  idx_mem  [depth];
	logic [depth-1:0] last_mem;

	logic [ptr_w-1:0] wr_ptr_q;
	logic [ptr_w-1:0] rd_ptr_q;
	logic [ptr_w:0]   count_q;
	logic             push;
	logic             pop;
	logic             full;
	logic             empty;

	assign full  = (count_q == (ptr_w + 1)'(depth));
	assign empty = (count_q == '0);

	// keep one slot spare for the read already issued
	assign in.hold = (count_q >= (ptr_w + 1)'(depth - 1));

	assign push = in.stb && !flush;
	assign pop  = out.stb && !out.hold;

	assign out.stb   = !empty && !flush;
	assign out.data  = data_mem[rd_ptr_q];
	assign out.index = idx_mem[rd_ptr_q];
	assign out.last  = last_mem[rd_ptr_q];

	always_ff @(posedge clk1) begin
		if (!rst_n || flush) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
		end
	end

	always_ff @(posedge clk1) begin
		if (push) begin
			data_mem[wr_ptr_q] <= in.data;
			idx_mem[wr_ptr_q]  <= in.index;
			last_mem[wr_ptr_q] <= in.last;
		end
	end

	// hold leads the engine reads by one cycle, so this must never fire
	a_no_overflow: assert property (@(posedge clk1) disable iff (!rst_n)
		push |-> !full);

endmodule

`default_nettype wire

// File: logic/oam_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module oam_writer (
	input  wire logic       clk1,
	input  wire logic       rst_n,
	input  wire logic       oam_busy,
	xfer_if.dst             in,
	output logic            oam_we,
	output dma_pkg::index_t oam_addr,
	output bus_pkg::byte_t  oam_wdata,
	output logic            done
);

	localparam dma_pkg::index_t len_idx = dma_pkg::index_t'(`DMA_LEN);

	// pixel unit owns OAM while busy, so stall the buffer head
	assign in.hold = oam_busy;

	assign oam_we    = in.stb && !oam_busy;
	assign oam_addr  = in.index;
	assign oam_wdata = in.data;

	// copy finishes with the write of index 159
	assign done = oam_we && in.last;

	a_addr_range: assert property (@(posedge clk1) disable iff (!rst_n)
		oam_we |-> (oam_addr < len_idx));

	// last flag only ever rides on the top index
	a_last_idx: assert property (@(posedge clk1) disable iff (!rst_n)
		done |-> (oam_addr == len_idx - 8'd1));

endmodule

`default_nettype wire

// File: logic/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top (
	input  wire logic            clk1,
	input  wire logic            rst_n,
	input  wire logic            reg_sel,
	input  wire logic            reg_wr,
	input  wire logic            reg_rd,
	input  wire bus_pkg::byte_t  cpu_wdata,
	output      bus_pkg::byte_t  cpu_rdata,
	output      bus_pkg::addr_t  ext_addr,
	output      logic            ext_rd,
	input  wire bus_pkg::byte_t  ext_rdata,
	output      bus_pkg::addr_t  vram_addr,
	output      logic            vram_rd,
	input  wire bus_pkg::byte_t  vram_rdata,
	output      logic            oam_we,
	output      dma_pkg::index_t oam_addr,
	output      bus_pkg::byte_t  oam_wdata,
	input  wire logic            oam_busy,
	output      logic            dma_run,
	output      logic            oam_blocked
);

	logic flush;
	logic done;

	xfer_if eng_buf ();
	xfer_if buf_oam ();

	dma_engine dma_engine_inst (
		.clk1       (clk1),
		.rst_n      (rst_n),
		.reg_sel    (reg_sel),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.ext_addr   (ext_addr),
		.ext_rd     (ext_rd),
		.ext_rdata  (ext_rdata),
		.vram_addr  (vram_addr),
		.vram_rd    (vram_rd),
		.vram_rdata (vram_rdata),
		.done       (done),
		.dma_run    (dma_run),
		.flush      (flush),
		.out        (eng_buf)
	);

	dma_buffer dma_buffer_inst (
		.clk1  (clk1),
		.rst_n (rst_n),
		.flush (flush),
		.in    (eng_buf),
		.out   (buf_oam)
	);

	oam_writer oam_writer_inst (
		.clk1      (clk1),
		.rst_n     (rst_n),
		.oam_busy  (oam_busy),
		.in        (buf_oam),
		.oam_we    (oam_we),
		.oam_addr  (oam_addr),
		.oam_wdata (oam_wdata),
		.done      (done)
	);

	assign oam_blocked = dma_run; // CPU loses OAM for the whole copy

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk1
);

	localparam time half_period = 50ns; // 100 ns cycle

	initial begin
		clk1 = 1'b0;
		forever begin
			#(half_period) clk1 = ~clk1;
		end
	end

endmodule

`default_nettype wire

// File: verif/dma_tb.sv
`timescale 1ns/1ps
`include "dma_defs.svh"
`default_nettype none

module dma_tb;

	logic            clk1;
	logic            rst_n;
	logic            reg_sel;
	logic            reg_wr;
	logic            reg_rd;
	bus_pkg::byte_t  cpu_wdata;
	bus_pkg::byte_t  cpu_rdata;
	bus_pkg::addr_t  ext_addr;
	logic            ext_rd;
	bus_pkg::byte_t  ext_rdata;
	bus_pkg::addr_t  vram_addr;
	logic            vram_rd;
	bus_pkg::byte_t  vram_rdata;
	logic            oam_we;
	dma_pkg::index_t oam_addr;
	bus_pkg::byte_t  oam_wdata;
	logic            oam_busy;
	logic            dma_run;
	logic            oam_blocked;

	bus_pkg::byte_t ext_mem  [65536];
	bus_pkg::byte_t vram_mem [65536];
	bus_pkg::byte_t exp_page;  // page of the copy under check
	int             start_seq; // bumped on every register write
	int             exp_idx;   // next OAM index the checker expects
	int             errors;
	int             chk_errors;
	logic           busy_mode;

	tb_clock tb_clock_inst (.clk1(clk1));

	dma_top dma_top_inst (
		.clk1(clk1), .rst_n(rst_n),
		.reg_sel(reg_sel), .reg_wr(reg_wr), .reg_rd(reg_rd),
		.cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
		.ext_addr(ext_addr), .ext_rd(ext_rd), .ext_rdata(ext_rdata),
		.vram_addr(vram_addr), .vram_rd(vram_rd), .vram_rdata(vram_rdata),
		.oam_we(oam_we), .oam_addr(oam_addr), .oam_wdata(oam_wdata),
		.oam_busy(oam_busy), .dma_run(dma_run), .oam_blocked(oam_blocked)
	);

	function automatic bit page_in_vram(input bus_pkg::byte_t page);
		return (page >= `DMA_VRAM_PAGE_LO) && (page <= `DMA_VRAM_PAGE_HI);
	endfunction

	// expected OAM byte for position idx of a copy from page
	function automatic bus_pkg::byte_t ref_byte(input bus_pkg::byte_t page, input int idx);
		bus_pkg::addr_t a;
		a = {page, 8'(idx)};
		if (page_in_vram(page))
			return vram_mem[a];
		return ext_mem[a];
	endfunction

	task automatic next_cycle();
		@(posedge clk1);
		#1;
	endtask

	task automatic report_bit(input string name, input logic got, input logic want);
		errors++;
		$display("FAILED time=%0t %s: got %b expected %b", $time, name, got, want);
	endtask

	task automatic report_byte(input string name, input bus_pkg::byte_t got,
		input bus_pkg::byte_t want);
		errors++;
		$display("FAILED time=%0t %s: got %02h expected %02h", $time, name, got, want);
	endtask

	task automatic read_page(output bus_pkg::byte_t value);
		reg_sel = 1'b1;
		reg_rd  = 1'b1;
		@(negedge clk1);
		value = cpu_rdata; // combinational read path
		next_cycle();
		reg_sel = 1'b0;
		reg_rd  = 1'b0;
	endtask

	// write the page register, then check the start timing
	task automatic start_copy(input bus_pkg::byte_t page, input bit fresh);
		reg_sel   = 1'b1;
		reg_wr    = 1'b1;
		cpu_wdata = page;
		exp_page  = page;
		start_seq++;
		next_cycle();
		reg_sel = 1'b0;
		reg_wr  = 1'b0;
		@(negedge clk1);
		if (fresh && dma_run !== 1'b0)
			report_bit("dma_run", dma_run, 1'b0);
		if ((ext_rd | vram_rd) !== 1'b0)
			report_bit("ext_rd|vram_rd", ext_rd | vram_rd, 1'b0);
		@(negedge clk1);
		if (dma_run !== 1'b1)
			report_bit("dma_run", dma_run, 1'b1);
		if ((ext_rd | vram_rd) !== 1'b1)
			report_bit("ext_rd|vram_rd", ext_rd | vram_rd, 1'b1); // first read at t+2
		next_cycle();
	endtask

	task automatic wait_copy_end(input int limit);
		int n;
		n = 0;
		while (dma_run === 1'b1 && n < limit) begin
			next_cycle();
			n++;
		end
		if (dma_run === 1'b1) begin
			errors++;
			$display("timeout: copy of page %02h still running after %0d cycles", exp_page, n);
		end else if (exp_idx != `DMA_LEN) begin
			errors++;
			$display("copy of page %02h ended after %0d OAM writes instead of %0d",
				exp_page, exp_idx, `DMA_LEN);
		end
	endtask

	task automatic wait_writes(input int count, input int limit);
		int n;
		n = 0;
		while (exp_idx < count && n < limit) begin
			next_cycle();
			n++;
		end
		if (exp_idx < count) begin
			errors++;
			$display("timeout: only %0d of %0d OAM writes seen after %0d cycles", exp_idx, count, n);
		end
	endtask

	// source memories answer a strobe with data in the next cycle
	initial begin : mem_model
		logic           ext_take;
		logic           vram_take;
		bus_pkg::addr_t ext_at;
		bus_pkg::addr_t vram_at;
		ext_rdata  = '0;
		vram_rdata = '0;
		forever begin
			@(negedge clk1);
			ext_take  = (ext_rd === 1'b1);
			vram_take = (vram_rd === 1'b1);
			ext_at    = ext_addr;
			vram_at   = vram_addr;
			next_cycle();
			if (ext_take)
				ext_rdata = ext_mem[ext_at];
			if (vram_take)
				vram_rdata = vram_mem[vram_at];
		end
	end

	initial begin : busy_gen
		int left;
		left     = 0;
		oam_busy = 1'b0;
		forever begin
			next_cycle();
			if (busy_mode) begin
				if (left == 0) begin
					oam_busy = !oam_busy; // random length bursts
					left     = 1 + int'($urandom % 7);
				end
				left--;
			end else begin
				oam_busy = 1'b0;
				left     = 0;
			end
		end
	end

	initial begin : write_checker
		int   seen_seq;
		logic fall_due;
		bit   vram_src;
		seen_seq   = 0;
		fall_due   = 1'b0;
		exp_idx    = 0;
		chk_errors = 0;
		forever begin
			@(negedge clk1);
			if (rst_n === 1'b1) begin
				if (fall_due && dma_run !== 1'b0) begin
					chk_errors++;
					$display("FAILED time=%0t dma_run: got %b expected 0", $time, dma_run);
				end
				fall_due = 1'b0;
				if (start_seq != seen_seq) begin // new register write
					seen_seq = start_seq;
					exp_idx  = 0;
				end
				if (oam_blocked !== dma_run) begin
					chk_errors++;
					$display("FAILED time=%0t oam_blocked: got %b expected %b",
						$time, oam_blocked, dma_run);
				end
				vram_src = page_in_vram(exp_page);
				if (ext_rd !== 1'b0 && vram_src) begin
					chk_errors++;
					$display("FAILED time=%0t ext_rd: got %b expected 0", $time, ext_rd);
				end
				if (vram_rd !== 1'b0 && !vram_src) begin
					chk_errors++;
					$display("FAILED time=%0t vram_rd: got %b expected 0", $time, vram_rd);
				end
				if (ext_rd === 1'b1 && ext_addr[15:8] !== exp_page) begin
					chk_errors++;
					$display("FAILED time=%0t ext_addr page: got %02h expected %02h",
						$time, ext_addr[15:8], exp_page);
				end
				if (vram_rd === 1'b1 && vram_addr[15:8] !== exp_page) begin
					chk_errors++;
					$display("FAILED time=%0t vram_addr page: got %02h expected %02h",
						$time, vram_addr[15:8], exp_page);
				end
				if (oam_we === 1'b1) begin
					if (exp_idx >= `DMA_LEN) begin
						chk_errors++;
						$display("OAM write at time %0t after all %0d bytes of page %02h",
							$time, `DMA_LEN, exp_page);
					end else begin
						if (oam_addr !== dma_pkg::index_t'(exp_idx)) begin
							chk_errors++;
							$display("FAILED time=%0t oam_addr: got %0d expected %0d",
								$time, oam_addr, exp_idx);
						end
						if (oam_wdata !== ref_byte(exp_page, exp_idx)) begin
							chk_errors++;
							$display("FAILED time=%0t oam_wdata: got %02h expected %02h",
								$time, oam_wdata, ref_byte(exp_page, exp_idx));
						end
						if (exp_idx == `DMA_LEN - 1)
							fall_due = 1'b1; // run ends at the next edge
					end
					exp_idx++;
				end
			end
		end
	end

	initial begin : stimulus
		int             n;
		bus_pkg::byte_t got;
		errors    = 0;
		start_seq = 0;
		exp_page  = '0;
		busy_mode = 1'b0;
		rst_n     = 1'b0;
		reg_sel   = 1'b0;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		cpu_wdata = '0;
		void'($urandom(42554));
		for (n = 0; n < 65536; n++) begin
			ext_mem[16'(n)]  = 8'($urandom);
			vram_mem[16'(n)] = 8'($urandom);
		end
		repeat (3) @(posedge clk1);
		#1;
		rst_n = 1'b1;

		// quiet after reset
		for (n = 0; n < 8; n++) begin
			@(negedge clk1);
			if (dma_run !== 1'b0)
				report_bit("dma_run", dma_run, 1'b0);
			if (oam_we !== 1'b0)
				report_bit("oam_we", oam_we, 1'b0);
			if (ext_rd !== 1'b0)
				report_bit("ext_rd", ext_rd, 1'b0);
			if (vram_rd !== 1'b0)
				report_bit("vram_rd", vram_rd, 1'b0);
			if (oam_blocked !== 1'b0)
				report_bit("oam_blocked", oam_blocked, 1'b0);
		end
		next_cycle();
		read_page(got);
		if (got !== 8'h00)
			report_byte("cpu_rdata", got, 8'h00);

		start_copy(8'hC1, 1'b1); // external bus page
		wait_copy_end(2000);
		read_page(got);
		if (got !== 8'hC1)
			report_byte("cpu_rdata", got, 8'hC1);

		start_copy(8'h85, 1'b1); // video RAM page
		wait_copy_end(2000);

		busy_mode = 1'b1;
		start_copy(8'h3A, 1'b1);
		wait_copy_end(5000);
		busy_mode = 1'b0;
		next_cycle();

		// restart halfway through
		start_copy(8'h12, 1'b1);
		wait_writes(60, 1000);
		start_copy(8'h9A, 1'b0);
		wait_copy_end(2000);
		read_page(got);
		if (got !== 8'h9A)
			report_byte("cpu_rdata", got, 8'h9A);

		repeat (4) next_cycle();
		$display("closing: stimulus errors %0d, checker errors %0d, total errors %0d",
			errors, chk_errors, errors + chk_errors);
		if (errors + chk_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/bus_pkg.sv
common/dma_pkg.sv
common/xfer_if.sv
dma/dma_engine.sv
dma/dma_buffer.sv
logic/oam_writer.sv
logic/dma_top.sv
verif/tb_clock.sv
verif/dma_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= dma_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
